/* hdl/pi_pkg.sv */
`default_nettype none

package pi_pkg;

	// a 3-bit channel number reaches channels 1 to 7
	localparam int pi_max_chan = 7;

	// encoded channel number, 0 means none
	typedef logic [2:0] pi_chan_t;

	// command port opcodes
	typedef enum logic [2:0] {
		PI_OP_NOP      = 3'd0,
		PI_OP_RESET    = 3'd1,
		PI_OP_SET_MASK = 3'd2,	// set pio bits from data
		PI_OP_CLR_MASK = 3'd3,	// clear pio bits from data
		PI_OP_ON       = 3'd4,
		PI_OP_OFF      = 3'd5,
		PI_OP_CLR_REQ  = 3'd6,	// withdraw pending pir bits
		PI_OP_DISMISS  = 3'd7	// drop highest hold
	} pi_op_e;

	// grant handshake toward the processor
	typedef enum logic [1:0] {
		GR_IDLE  = 2'd0,
		GR_OFFER = 2'd1,	// int_req up, waiting for int_ack
		GR_DROP  = 2'd2	// waiting for int_ack to fall
	} pi_grant_e;

endpackage

`default_nettype wire

/* hdl/pi_control.sv */
`timescale 1ns/1ps
`default_nettype none

module pi_control import pi_pkg::*; #(
	parameter int NUM_CHAN = 7
) (
	input  logic              clk,
	input  logic              pi_reset,
	input  logic              cmd_req,
	input  pi_op_e            cmd_op,
	input  logic [1:NUM_CHAN] cmd_data,
	output logic              cmd_ack,
	output logic              active,
	output logic              clr_all,
	output logic              dismiss,
	output logic [1:NUM_CHAN] mask_set,
	output logic [1:NUM_CHAN] mask_clr,
	output logic [1:NUM_CHAN] req_clr
);

	logic cmd_start;	// first cycle of a command
	logic go_on;
	logic go_off;

	// ack not yet up, so this is a fresh request
	assign cmd_start = cmd_req & ~cmd_ack;

	// four-phase ack follows req one edge later
	always_ff @(posedge clk) begin
		if (pi_reset) begin
			cmd_ack <= 1'b0;
		end else begin
			cmd_ack <= cmd_req;
		end
	end

	// opcode decode into strobes for the slices
	always_comb begin
		clr_all  = 1'b0;
		dismiss  = 1'b0;
		go_on    = 1'b0;
		go_off   = 1'b0;
		mask_set = '0;
		mask_clr = '0;
		req_clr  = '0;
		if (cmd_start) begin
			case (cmd_op)
				PI_OP_RESET:
					clr_all = 1'b1;
				PI_OP_SET_MASK:
					mask_set = cmd_data;
				PI_OP_CLR_MASK:
					mask_clr = cmd_data;
				PI_OP_ON:
					go_on = 1'b1;
				PI_OP_OFF:
					go_off = 1'b1;
				PI_OP_CLR_REQ:
					req_clr = cmd_data;
				PI_OP_DISMISS:
					dismiss = 1'b1;
				default: begin
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (pi_reset) begin
			active <= 1'b0;
		end else if (clr_all | go_off) begin
			active <= 1'b0;
		end else if (go_on) begin
			active <= 1'b1;
		end
	end

	// ack only answers a live request
	a_ack_needs_req: assert property (@(posedge clk) disable iff (pi_reset)
		$rose(cmd_ack) |-> $past(cmd_req));

	// outside must hold the opcode through the handshake
	a_op_stable: assert property (@(posedge clk) disable iff (pi_reset)
		cmd_req && cmd_ack |-> $stable(cmd_op));

endmodule

`default_nettype wire

/* hdl/pi_channel.sv */
`timescale 1ns/1ps
`default_nettype none

module pi_channel (
	input  logic clk,
	input  logic pi_reset,
	input  logic dev_req,
	input  logic mask_set,
	input  logic mask_clr,
	input  logic req_clr,
	input  logic clr_all,
	input  logic dismiss,
	input  logic take,
	input  logic ok_in,
	input  logic held_above_in,
	output logic ok_out,
	output logic held_above_out,
	output logic chan_req,
	output logic pio,
	output logic pir,
	output logic pih
);

	logic dismiss_me;	// this hold is the highest one

	// priority chain, blocked by a hold or a request here
	assign chan_req       = ok_in & ~pih & pir;
	assign ok_out         = ok_in & ~pih & ~pir;
	assign held_above_out = held_above_in | pih;

	assign dismiss_me = dismiss & pih & ~held_above_in;

	// mask
	always_ff @(posedge clk) begin
		if (pi_reset | clr_all) begin
			pio <= 1'b0;
		end else if (mask_set) begin
			pio <= 1'b1;
		end else if (mask_clr) begin
			pio <= 1'b0;
		end
	end

	// request, captured only through the mask
	always_ff @(posedge clk) begin
		if (pi_reset | clr_all) begin
			pir <= 1'b0;
		end else if (take | req_clr) begin
			pir <= 1'b0;
		end else if (dev_req & pio) begin
			pir <= 1'b1;
		end
	end

	// hold
	always_ff @(posedge clk) begin
		if (pi_reset) begin
			pih <= 1'b0;
		end else if (take) begin
			pih <= 1'b1;	// a grant in flight still lands
		end else if (clr_all | dismiss_me) begin
			pih <= 1'b0;
		end
	end

	a_req_not_held: assert property (@(posedge clk) disable iff (pi_reset)
		!(chan_req && pih));

	// take only reaches a channel without a hold
	a_take_unheld: assert property (@(posedge clk) disable iff (pi_reset)
		take |-> !pih);

endmodule

`default_nettype wire

/* hdl/pi_grant.sv */
`timescale 1ns/1ps
`default_nettype none

module pi_grant import pi_pkg::*; #(
	parameter int NUM_CHAN = 7
) (
	input  logic              clk,
	input  logic              pi_reset,
	input  logic [1:NUM_CHAN] chan_req,
	input  logic              int_ack,
	output logic              int_req,
	output pi_chan_t          int_chan,
	output logic [1:NUM_CHAN] take
);

	pi_grant_e         state;
	pi_chan_t          win_chan;	// encoded chain winner
	logic [1:NUM_CHAN] take_vec;	// int_chan back to one-hot
	logic              have_win;

	// channel number must fit in pi_chan_t
	if (NUM_CHAN < 1 || NUM_CHAN > pi_max_chan) begin : g_chan_range
		$error("pi_grant: NUM_CHAN out of range");
	end

	// chain gives at most one winner, so or-ing indices is enough
	always_comb begin
		win_chan = '0;
		for (int i = 1; i <= NUM_CHAN; i++) begin
			if (chan_req[i]) begin
				win_chan = win_chan | pi_chan_t'(i);
			end
		end
	end

	assign have_win = (win_chan != '0);

	always_comb begin
		take_vec = '0;
		for (int i = 1; i <= NUM_CHAN; i++) begin
			take_vec[i] = (int_chan == pi_chan_t'(i));
		end
	end

	always_ff @(posedge clk) begin
		if (pi_reset) begin
			state    <= GR_IDLE;
			int_req  <= 1'b0;
			int_chan <= '0;
			take     <= '0;
		end else begin
			take <= '0;	// single cycle pulse
			case (state)
				GR_IDLE: begin
					if (have_win) begin
						int_chan <= win_chan;
						int_req  <= 1'b1;
						state    <= GR_OFFER;
					end
				end
				GR_OFFER: begin
					// offer stays frozen until the processor answers
					if (int_ack) begin
						take    <= take_vec;
						int_req <= 1'b0;
						state   <= GR_DROP;
					end
				end
				GR_DROP: begin
					if (!int_ack) begin
						state <= GR_IDLE;
					end
				end
				default: begin
					state <= GR_IDLE;
				end
			endcase
		end
	end

	// slices must agree on a single winner
	a_one_winner: assert property (@(posedge clk) disable iff (pi_reset)
		$onehot0(chan_req));

	a_chan_stable: assert property (@(posedge clk) disable iff (pi_reset)
		state == GR_OFFER && $past(state) == GR_OFFER |-> $stable(int_chan));

endmodule

`default_nettype wire

/* hdl/pi_top.sv */
`timescale 1ns/1ps
`default_nettype none

module pi_top import pi_pkg::*; #(
	parameter int NUM_CHAN = 7
) (
	input  logic              clk,
	input  logic              pi_reset,
	input  logic              cmd_req,
	input  pi_op_e            cmd_op,
	input  logic [1:NUM_CHAN] cmd_data,
	input  logic [1:NUM_CHAN] dev_req,
	input  logic              int_ack,
	output logic              cmd_ack,
	output logic              int_req,
	output pi_chan_t          int_chan,
	output logic              pi_active,
	output logic [1:NUM_CHAN] pio,
	output logic [1:NUM_CHAN] pir,
	output logic [1:NUM_CHAN] pih
);

	logic                clr_all;
	logic                dismiss;
	logic [1:NUM_CHAN]   mask_set;
	logic [1:NUM_CHAN]   mask_clr;
	logic [1:NUM_CHAN]   req_clr;
	logic [1:NUM_CHAN]   chan_req;
	logic [1:NUM_CHAN]   take;
	logic [1:NUM_CHAN+1] ok;	// priority chain, channel 1 first
	logic [1:NUM_CHAN+1] held_above;

	assign ok[1]         = pi_active;
	assign held_above[1] = 1'b0;

	pi_control #(
		.NUM_CHAN (NUM_CHAN)
	) u_control (
		.clk      (clk),
		.pi_reset (pi_reset),
		.cmd_req  (cmd_req),
		.cmd_op   (cmd_op),
		.cmd_data (cmd_data),
		.cmd_ack  (cmd_ack),
		.active   (pi_active),
		.clr_all  (clr_all),
		.dismiss  (dismiss),
		.mask_set (mask_set),
		.mask_clr (mask_clr),
		.req_clr  (req_clr)
	);

	for (genvar i = 1; i <= NUM_CHAN; i++) begin : g_chan
		pi_channel u_chan (
			.clk            (clk),
			.pi_reset       (pi_reset),
			.dev_req        (dev_req[i]),
			.mask_set       (mask_set[i]),
			.mask_clr       (mask_clr[i]),
			.req_clr        (req_clr[i]),
			.clr_all        (clr_all),
			.dismiss        (dismiss),
			.take           (take[i]),
			.ok_in          (ok[i]),
			.held_above_in  (held_above[i]),
			.ok_out         (ok[i+1]),
			.held_above_out (held_above[i+1]),
			.chan_req       (chan_req[i]),
			.pio            (pio[i]),
			.pir            (pir[i]),
			.pih            (pih[i])
		);
	end

	pi_grant #(
		.NUM_CHAN (NUM_CHAN)
	) u_grant (
		.clk      (clk),
		.pi_reset (pi_reset),
		.chan_req (chan_req),
		.int_ack  (int_ack),
		.int_req  (int_req),
		.int_chan (int_chan),
		.take     (take)
	);

endmodule

`default_nettype wire

/* verification/pi_model.svh */
`ifndef PI_MODEL_SVH
`define PI_MODEL_SVH

// first channel holding or requesting stops the chain
function automatic pi_chan_t model_winner(input logic act, input chan_vec_t pir_v,
		input chan_vec_t pih_v);
	pi_chan_t win;
	logic     blocked;
	win = '0;
	blocked = !act;
	for (int i = 1; i <= NUM_CHAN; i++) begin
		if (!blocked && (pih_v[i] || pir_v[i])) begin
			if (!pih_v[i]) begin
				win = pi_chan_t'(i);
			end
			blocked = 1'b1;
		end
	end
	return win;
endfunction

// only the highest hold goes away
function automatic chan_vec_t model_dismiss(input chan_vec_t pih_v);
	chan_vec_t res;
	logic      done;
	res = pih_v;
	done = 1'b0;
	for (int i = 1; i <= NUM_CHAN; i++) begin
		if (!done && res[i]) begin
			res[i] = 1'b0;
			done = 1'b1;
		end
	end
	return res;
endfunction

// channel number to one-hot vector
function automatic chan_vec_t chan_bit(input int c);
	chan_vec_t res;
	res = '0;
	if (c >= 1 && c <= NUM_CHAN) begin
		res[c] = 1'b1;
	end
	return res;
endfunction

`endif

/* verification/pi_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module pi_tb import pi_pkg::*;;

	localparam int NUM_CHAN   = 7;
	localparam int CLK_PERIOD = 100;
	localparam int N_TESTS    = 6;
	localparam int DRIVE_DLY  = 10;

	typedef logic [1:NUM_CHAN] chan_vec_t;

	logic      clk;
	logic      pi_reset;
	logic      cmd_req;
	pi_op_e    cmd_op;
	chan_vec_t cmd_data;
	chan_vec_t dev_req;
	logic      int_ack;
	logic      cmd_ack;
	logic      int_req;
	pi_chan_t  int_chan;
	logic      pi_active;
	chan_vec_t pio;
	chan_vec_t pir;
	chan_vec_t pih;

	int    errors = 0;
	int    tests = 0;
	int    passed = 0;
	int    test_errs = 0;
	string cur_test;

	// previous cycle, for the offer monitor
	logic      prev_int_req = 1'b0;
	logic      prev_active = 1'b0;
	pi_chan_t  prev_chan = '0;
	chan_vec_t prev_pir = '0;
	chan_vec_t prev_pih = '0;

	pi_top #(
		.NUM_CHAN (NUM_CHAN)
	) uut (
		.clk       (clk),
		.pi_reset  (pi_reset),
		.cmd_req   (cmd_req),
		.cmd_op    (cmd_op),
		.cmd_data  (cmd_data),
		.dev_req   (dev_req),
		.int_ack   (int_ack),
		.cmd_ack   (cmd_ack),
		.int_req   (int_req),
		.int_chan  (int_chan),
		.pi_active (pi_active),
		.pio       (pio),
		.pir       (pir),
		.pih       (pih)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	initial begin
		#(N_TESTS * 200 * CLK_PERIOD);
		$display("watchdog: run did not finish within %0d cycles", N_TESTS * 200);
		$display("=== FAIL ===");
		$finish;
	end

	task automatic check_chan(input string name, input pi_chan_t exp, input pi_chan_t act);
		if (exp !== act) begin
			$display("[ERROR] %s: %s expected %0d actual %0d", cur_test, name, exp, act);
			errors++;
		end
	endtask

	task automatic check_mask(input string name, input chan_vec_t exp, input chan_vec_t act);
		if (exp !== act) begin
			$display("[ERROR] %s: %s expected %b actual %b", cur_test, name, exp, act);
			errors++;
		end
	endtask

	task automatic check_bit(input string name, input logic exp, input logic act);
		if (exp !== act) begin
			$display("[ERROR] %s: %s expected %b actual %b", cur_test, name, exp, act);
			errors++;
		end
	endtask

	task automatic check_count(input string name, input int exp, input int act);
		if (exp != act) begin
			$display("[ERROR] %s: %s expected %0d actual %0d", cur_test, name, exp, act);
			errors++;
		end
	endtask

	task automatic next_cycle();
		@(posedge clk);
		#DRIVE_DLY;
	endtask

	task automatic pulse_dev(input chan_vec_t lines);
		dev_req = lines;
		next_cycle();
		dev_req = '0;
	endtask

	task automatic do_cmd(input pi_op_e op, input chan_vec_t data);
		int n;
		cmd_op = op;
		cmd_data = data;
		cmd_req = 1'b1;
		n = 0;
		do begin
			next_cycle();
			n++;
		end while (!cmd_ack && n < 20);
		if (!cmd_ack) begin
			$display("%s: command %s was never acknowledged", cur_test, op.name());
			errors++;
		end
		cmd_req = 1'b0;
		n = 0;
		while (cmd_ack && n < 20) begin
			next_cycle();
			n++;
		end
		if (cmd_ack) begin
			$display("%s: cmd_ack stayed high after cmd_req fell", cur_test);
			errors++;
		end
	endtask

	task automatic wait_offer();
		int n;
		n = 0;
		while (!int_req && n < 20) begin
			next_cycle();
			n++;
		end
		if (!int_req) begin
			$display("%s: no interrupt offer arrived", cur_test);
			errors++;
		end
	endtask

	// processor side, int_ack withheld for hold cycles
	task automatic accept(input int hold, output pi_chan_t chan);
		int n;
		wait_offer();
		repeat (hold) next_cycle();
		chan = int_chan;
		int_ack = 1'b1;
		n = 0;
		while (int_req && n < 20) begin
			next_cycle();
			n++;
		end
		if (int_req) begin
			$display("%s: int_req never fell after int_ack", cur_test);
			errors++;
		end
		int_ack = 1'b0;
		next_cycle();	// hold lands here
	endtask

	task automatic begin_test(input string name);
		cur_test = name;
		test_errs = errors;
	endtask

	task automatic end_test();
		tests++;
		if (errors == test_errs) begin
			passed++;
			$display("test %-20s ok", cur_test);
		end else begin
			$display("test %-20s failed with %0d errors", cur_test, errors - test_errs);
		end
	endtask

	// every offer checked against the chain state it was taken from
	always @(posedge clk) begin
		#(DRIVE_DLY / 2);
		if (!pi_reset) begin
			if (int_req && !prev_int_req) begin
				check_chan("offer", model_winner(prev_active, prev_pir, prev_pih), int_chan);
			end else if (int_req && prev_int_req) begin
				check_chan("offer stable", prev_chan, int_chan);
			end
		end
		prev_int_req = int_req;
		prev_active = pi_active;
		prev_chan = int_chan;
		prev_pir = pir;
		prev_pih = pih;
	end

	initial begin
		chan_vec_t data;
		chan_vec_t exp;
		pi_chan_t  got;
		pi_chan_t  first;
		int        n;
		int        c;
		int        hi;
		int        lo;
		int        m;

		void'($urandom(32'h4cb9cd13));
		pi_reset = 1'b1;
		cmd_req = 1'b0;
		cmd_op = PI_OP_NOP;
		cmd_data = '0;
		dev_req = '0;
		int_ack = 1'b0;
		repeat (3) @(posedge clk);
		#DRIVE_DLY;
		pi_reset = 1'b0;

		begin_test("mask");
		exp = '0;
		repeat (8) begin
			data = chan_vec_t'($urandom);
			do_cmd(PI_OP_SET_MASK, data);
			exp = exp | data;
			check_mask("pio after set", exp, pio);
			data = chan_vec_t'($urandom);
			do_cmd(PI_OP_CLR_MASK, data);
			exp = exp & ~data;
			check_mask("pio after clear", exp, pio);
		end
		dev_req = ~pio;	// unmasked lines only
		repeat (3) next_cycle();
		dev_req = '0;
		check_mask("unmasked pir", '0, pir);
		end_test();

		begin_test("capture priority");
		do_cmd(PI_OP_SET_MASK, '1);
		do_cmd(PI_OP_ON, '0);
		c = $urandom_range(NUM_CHAN, 1);
		pulse_dev(chan_bit(c));
		n = 1;
		while (!int_req && n < 10) begin
			next_cycle();
			n++;
		end
		check_count("request latency", 2, n);
		accept(0, got);
		do_cmd(PI_OP_DISMISS, '0);
		repeat (4) begin
			pulse_dev(chan_vec_t'($urandom));
			n = 0;
			while (pir != '0 && n < NUM_CHAN) begin
				accept(0, got);
				check_mask("single hold", chan_bit(int'(got)), pih);
				do_cmd(PI_OP_DISMISS, '0);
				n++;
			end
			check_mask("all served", '0, pir);
		end
		end_test();

		begin_test("accept");
		hi = $urandom_range(NUM_CHAN - 1, 1);
		lo = $urandom_range(NUM_CHAN, hi + 1);
		pulse_dev(chan_bit(hi) | chan_bit(lo));
		accept(0, got);
		check_chan("accepted channel", pi_chan_t'(hi), got);
		check_mask("hold set", chan_bit(hi), pih);
		check_mask("request left", chan_bit(lo), pir);
		repeat (8) next_cycle();
		check_bit("lower blocked", 1'b0, int_req);
		do_cmd(PI_OP_DISMISS, '0);
		accept(0, got);
		check_chan("lower after dismiss", pi_chan_t'(lo), got);
		do_cmd(PI_OP_DISMISS, '0);
		end_test();

		begin_test("back-pressure");
		lo = $urandom_range(NUM_CHAN, 3);
		hi = $urandom_range(lo - 2, 1);
		pulse_dev(chan_bit(lo));
		wait_offer();
		first = int_chan;
		pulse_dev(chan_bit(hi));	// higher request during the offer
		accept($urandom_range(10, 2), got);
		check_chan("frozen offer", first, got);
		check_chan("first offer", pi_chan_t'(lo), first);
		accept(0, got);
		check_chan("higher after release", pi_chan_t'(hi), got);
		end_test();

		begin_test("dismiss");
		m = hi + 1;	// below hi, above lo
		pulse_dev(chan_bit(m));
		repeat (6) next_cycle();
		check_bit("blocked by hold", 1'b0, int_req);
		exp = model_dismiss(pih);
		do_cmd(PI_OP_DISMISS, '0);
		check_mask("pih after dismiss", exp, pih);
		accept(0, got);
		check_chan("next lower offer", pi_chan_t'(m), got);
		repeat (2) begin
			exp = model_dismiss(pih);
			do_cmd(PI_OP_DISMISS, '0);
			check_mask("pih after dismiss", exp, pih);
		end
		check_mask("holds empty", '0, pih);
		end_test();

		begin_test("off and reset");
		do_cmd(PI_OP_OFF, '0);
		c = $urandom_range(NUM_CHAN, 1);
		pulse_dev(chan_bit(c));
		repeat (6) next_cycle();
		check_bit("no offer while off", 1'b0, int_req);
		check_mask("pir kept while off", chan_bit(c), pir);
		do_cmd(PI_OP_ON, '0);
		accept(0, got);
		check_chan("offer after on", pi_chan_t'(c), got);
		pulse_dev(chan_bit(c));	// request behind its own hold
		do_cmd(PI_OP_RESET, '0);
		check_mask("pio after reset", '0, pio);
		check_mask("pir after reset", '0, pir);
		check_mask("pih after reset", '0, pih);
		check_bit("active after reset", 1'b0, pi_active);
		end_test();

		$display("%0d tests, %0d passed, %0d errors", tests, passed, errors);
		if (errors == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

	`include "pi_model.svh"

endmodule

`default_nettype wire

/* vlog.f */
+incdir+verification
hdl/pi_pkg.sv
hdl/pi_control.sv
hdl/pi_channel.sv
hdl/pi_grant.sv
hdl/pi_top.sv
verification/pi_tb.sv

/* Makefile */
TOOL       = verilator
TOP        = pi_tb
FLIST      = vlog.f
FLAGS      = --binary --timing --assert -j 0
LINT_FLAGS = --lint-only --timing
BUILD      = obj_dir
LOG        = sim.log
PASS_STR   = === PASS ===

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) $(LINT_FLAGS) --top-module $(TOP) -f $(FLIST)

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -qxF "$(PASS_STR)" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
